// ==== design/icache_pkg.sv ====
package icache_pkg;

    // address geometry
    localparam int addr_width  = 32;
    localparam int line_width  = 4;
    localparam int cache_width = 4;
    localparam int line_count  = 2 ** cache_width;
    localparam int word_width  = line_width - 2;
    localparam int tag_width   = addr_width - cache_width - line_width;

    // arlen for one full line
    localparam int burst_len = 2 ** word_width - 1;

    // refill FSM encoding
    localparam logic [1:0] state_idle    = 2'd0;
    localparam logic [1:0] state_request = 2'd1;
    localparam logic [1:0] state_fill    = 2'd2;

    // fetch address, seen as a byte address or split into cache fields
    typedef union packed {
        logic [addr_width-1:0] raw;
        struct packed {
            logic [tag_width-1:0]   tag;
            logic [cache_width-1:0] set;
            logic [word_width-1:0]  word;
            logic [1:0]             byte_sel;
        } fields;
    } fetch_addr_t;

endpackage

// ==== design/cache_line.sv ====
`timescale 1ns/1ps

module cache_line (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                clear,
    input  logic                                write_en,
    input  logic [icache_pkg::tag_width-1:0]    tag_in,
    input  logic [icache_pkg::word_width-1:0]   word_in,
    input  logic [31:0]                         data_in,
    input  logic                                set_valid,
    output logic                                valid,
    output logic [icache_pkg::tag_width-1:0]    tag,
    output logic [31:0]                         data_out,
    input  logic [icache_pkg::word_width-1:0]   word_sel
);
    import icache_pkg::*;

    logic [31:0] words [2 ** word_width];

    // valid bit, clear wins over a fill completing
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid <= 1'b0;
        end else if (clear) begin
            valid <= 1'b0;
        end else if (set_valid) begin
            valid <= 1'b1;
        end
    end

    // each beat carries the tag of the line being filled
    always_ff @(posedge clk) begin
        if (write_en) begin
            words[word_in] <= data_in;
            tag            <= tag_in;
        end
    end

    assign data_out = words[word_sel];

endmodule

// ==== design/axi_read_burst.sv ====
`timescale 1ns/1ps

module axi_read_burst (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                fill_start,
    input  icache_pkg::fetch_addr_t             fill_addr,
    output logic [31:0]                         araddr,
    output logic [7:0]                          arlen,
    output logic [2:0]                          arsize,
    output logic [1:0]                          arburst,
    output logic                                arvalid,
    input  logic                                arready,
    input  logic [31:0]                         rdata,
    input  logic [1:0]                          rresp,
    input  logic                                rlast,
    input  logic                                rvalid,
    output logic                                rready,
    output logic                                beat_valid,
    output logic [icache_pkg::word_width-1:0]   beat_index,
    output logic [31:0]                         beat_data,
    output logic                                fill_done
);
    import icache_pkg::*;

    logic [addr_width-1:0] line_addr;
    logic                  req_pending;
    logic                  data_phase;
    logic [word_width-1:0] beat_count;

    // fixed burst shape: one line of words, incrementing
    assign arlen   = 8'(burst_len);
    assign arsize  = 3'(line_width - word_width);
    assign arburst = 2'b01;
    assign araddr  = line_addr;
    assign arvalid = req_pending;

    // no back-pressure on R
    assign rready = 1'b1;

    always_ff @(posedge clk) begin
        if (fill_start) begin
            line_addr <= {fill_addr.fields.tag, fill_addr.fields.set, {line_width{1'b0}}};
        end
    end

    // AR stays up until accepted
    always_ff @(posedge clk) begin
        if (!rst) begin
            req_pending <= 1'b0;
        end else if (fill_start) begin
            req_pending <= 1'b1;
        end else if (req_pending && arready) begin
            req_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            data_phase <= 1'b0;
            beat_count <= '0;
        end else if (req_pending && arready) begin
            data_phase <= 1'b1;
            beat_count <= '0;
        end else if (beat_valid) begin
            beat_count <= beat_count + word_width'(1);
            if (rlast) begin
                data_phase <= 1'b0;
            end
        end
    end

    // beats pass straight through to the line
    assign beat_valid = data_phase && rvalid && rready;
    assign beat_index = beat_count;
    assign beat_data  = rdata;
    assign fill_done  = beat_valid && rlast;

endmodule

// ==== design/inst_cache.sv ====
`timescale 1ns/1ps

module inst_cache (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                read_en,
    input  logic                                flush,
    input  icache_pkg::fetch_addr_t             addr,
    output logic                                ready,
    output logic [31:0]                         data_out,
    output logic                                fill_start,
    output icache_pkg::fetch_addr_t             fill_addr,
    input  logic                                beat_valid,
    input  logic [icache_pkg::word_width-1:0]   beat_index,
    input  logic [31:0]                         beat_data,
    input  logic                                fill_done
);
    import icache_pkg::*;

    logic [1:0]            state;
    logic [1:0]            next_state;
    fetch_addr_t           miss_addr;
    logic                  hit;
    logic                  miss;
    logic                  filling;

    logic [line_count-1:0] line_valid;
    logic [line_count-1:0] line_write;
    logic [line_count-1:0] line_set_valid;
    logic [tag_width-1:0]  line_tag [line_count];
    logic [31:0]           line_word [line_count];

    assign filling = state == state_fill;

    // line array, only the set being refilled takes beats
    for (genvar i = 0; i < line_count; i++) begin : g_line
        assign line_write[i] = filling && beat_valid
                               && miss_addr.fields.set == cache_width'(i);
        assign line_set_valid[i] = line_write[i] && fill_done;

        cache_line u_line (
            .clk       (clk),
            .rst       (rst),
            .clear     (flush),
            .write_en  (line_write[i]),
            .tag_in    (miss_addr.fields.tag),
            .word_in   (beat_index),
            .data_in   (beat_data),
            .set_valid (line_set_valid[i]),
            .valid     (line_valid[i]),
            .tag       (line_tag[i]),
            .data_out  (line_word[i]),
            .word_sel  (addr.fields.word)
        );
    end

    // tag compare on the addressed set
    assign hit = line_valid[addr.fields.set]
                 && line_tag[addr.fields.set] == addr.fields.tag;
    assign miss = state == state_idle && read_en && !hit;

    assign ready    = state == state_idle && hit;
    assign data_out = ready ? line_word[addr.fields.set] : 32'd0;

    assign fill_start = state == state_request;
    assign fill_addr  = miss_addr;

    always_comb begin
        next_state = state;
        case (state)
            state_idle: begin
                if (miss) begin
                    next_state = state_request;
                end
            end
            state_request: begin
                next_state = state_fill;
            end
            state_fill: begin
                // last beat lands on the same edge
                if (fill_done) begin
                    next_state = state_idle;
                end
            end
            default: begin
                next_state = state_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= state_idle;
        end else begin
            state <= next_state;
        end
    end

    // line-aligned copy of the missing address
    always_ff @(posedge clk) begin
        if (miss) begin
            miss_addr.raw <= {addr.fields.tag, addr.fields.set, {line_width{1'b0}}};
        end
    end

endmodule

// ==== design/icache_top.sv ====
`timescale 1ns/1ps

module icache_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        read_en,
    input  logic                        flush,
    input  icache_pkg::fetch_addr_t     addr,
    output logic                        ready,
    output logic [31:0]                 data_out,
    output logic [31:0]                 araddr,
    output logic [7:0]                  arlen,
    output logic [2:0]                  arsize,
    output logic [1:0]                  arburst,
    output logic                        arvalid,
    input  logic                        arready,
    input  logic [31:0]                 rdata,
    input  logic [1:0]                  rresp,
    input  logic                        rlast,
    input  logic                        rvalid,
    output logic                        rready
);
    import icache_pkg::*;

    // refill link between cache and burst engine
    logic                  fill_start;
    fetch_addr_t           fill_addr;
    logic                  beat_valid;
    logic [word_width-1:0] beat_index;
    logic [31:0]           beat_data;
    logic                  fill_done;

    inst_cache u_cache (
        .clk        (clk),
        .rst        (rst),
        .read_en    (read_en),
        .flush      (flush),
        .addr       (addr),
        .ready      (ready),
        .data_out   (data_out),
        .fill_start (fill_start),
        .fill_addr  (fill_addr),
        .beat_valid (beat_valid),
        .beat_index (beat_index),
        .beat_data  (beat_data),
        .fill_done  (fill_done)
    );

    axi_read_burst u_burst (
        .clk        (clk),
        .rst        (rst),
        .fill_start (fill_start),
        .fill_addr  (fill_addr),
        .araddr     (araddr),
        .arlen      (arlen),
        .arsize     (arsize),
        .arburst    (arburst),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready),
        .beat_valid (beat_valid),
        .beat_index (beat_index),
        .beat_data  (beat_data),
        .fill_done  (fill_done)
    );

endmodule

// ==== verif/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int          depth    = 1024,
    parameter logic [31:0] fill_key = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    input  logic        ar_hold,
    input  logic        r_hold
);
    localparam int index_width = $clog2(depth);

    logic [31:0] mem [depth];
    logic        busy;
    logic [31:0] beat_addr;
    logic [7:0]  beats_left;

    // each word holds its own byte address, scrambled
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = (32'(i) << 2) ^ fill_key;
        end
    end

    // one burst at a time, holds come from the testbench LFSR
    assign arready = rst && !busy && !ar_hold;
    assign rvalid  = busy && !r_hold;
    assign rdata   = rvalid ? mem[beat_addr[index_width+1:2]] : 32'd0;
    assign rlast   = rvalid && beats_left == 8'd0;
    assign rresp   = 2'b00;

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy       <= 1'b0;
            beat_addr  <= 32'd0;
            beats_left <= 8'd0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                busy       <= 1'b1;
                beat_addr  <= araddr;
                beats_left <= arlen;
            end
        end else if (rvalid && rready) begin
            if (beats_left == 8'd0) begin
                busy <= 1'b0;
            end
            beat_addr  <= beat_addr + 32'd4;
            beats_left <= beats_left - 8'd1;
        end
    end

endmodule

// ==== verif/icache_assert.sv ====
`timescale 1ns/1ps

module icache_assert (
    input logic                            clk,
    input logic                            rst,
    input logic                            arvalid,
    input logic                            arready,
    input logic [icache_pkg::addr_width-1:0] araddr,
    input logic                            ready
);
    import icache_pkg::*;

    // AR request stays put until taken
    assert property (@(posedge clk) disable iff (!rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr changed before arready");

    assert property (@(posedge clk) disable iff (!rst)
        arvalid |-> araddr[line_width-1:0] == '0)
        else $error("araddr is not line aligned");

    // no hit is reported while a refill request is open
    assert property (@(posedge clk) disable iff (!rst)
        !(ready && arvalid))
        else $error("ready and arvalid high in the same cycle");

endmodule

// ==== verif/tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache;
    import icache_pkg::*;

    localparam logic [31:0] seed            = 32'h1cd6_d39f;
    localparam int          mem_depth       = 1024;
    localparam logic [31:0] fill_key        = 32'h5a3c_96e1;
    localparam int          random_reads    = 60;
    localparam int          evict_reads     = 8;
    localparam int          gap_reads       = 80;
    localparam int          total_reads     = 1 + random_reads + 5 + evict_reads
                                              + 2 * line_count + gap_reads;
    // request and four beats stretched by gaps
    localparam int          worst_fill      = 64;
    localparam int          watchdog_cycles = (total_reads + 16) * worst_fill;

    logic                 clk;
    logic                 rst;
    logic                 read_en;
    logic                 flush;
    fetch_addr_t          addr;
    logic                 ready;
    logic [31:0]          data_out;
    logic [31:0]          araddr;
    logic [7:0]           arlen;
    logic [2:0]           arsize;
    logic [1:0]           arburst;
    logic                 arvalid;
    logic                 arready;
    logic [31:0]          rdata;
    logic [1:0]           rresp;
    logic                 rlast;
    logic                 rvalid;
    logic                 rready;
    logic                 ar_hold;
    logic                 r_hold;

    logic [31:0]          lfsr;
    logic                 gaps_on;
    int                   error_count;
    int                   tests_run;
    int                   ar_count;
    logic [31:0]          last_araddr;
    logic                 model_valid [line_count];
    logic [tag_width-1:0] model_tag [line_count];

    icache_top dut0 (
        .clk(clk), .rst(rst), .read_en(read_en), .flush(flush), .addr(addr),
        .ready(ready), .data_out(data_out), .araddr(araddr), .arlen(arlen),
        .arsize(arsize), .arburst(arburst), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready)
    );

    axi_mem_model #(.depth(mem_depth), .fill_key(fill_key)) u_mem (
        .clk(clk), .rst(rst), .araddr(araddr), .arlen(arlen), .arvalid(arvalid),
        .arready(arready), .rdata(rdata), .rresp(rresp), .rlast(rlast),
        .rvalid(rvalid), .rready(rready), .ar_hold(ar_hold), .r_hold(r_hold)
    );

    bind icache_top icache_assert u_assert (
        .clk(clk), .rst(rst), .arvalid(arvalid), .arready(arready),
        .araddr(araddr), .ready(ready)
    );

    always #5 clk = ~clk;

    // galois step with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic take_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = 32'd0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], take_bit()};
        end
        return value;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ fill_key;
    endfunction

    // step to 1 ns past the next edge and draw new memory gaps
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (gaps_on) begin
            ar_hold = take_bit();
            r_hold  = take_bit();
        end else begin
            ar_hold = 1'b0;
            r_hold  = 1'b0;
        end
    endtask

    task automatic fetch(input logic [31:0] a, output logic was_hit);
        fetch_addr_t fa;
        logic        expect_hit;
        int          ar_before;
        int          waited;
        fa.raw     = a;
        expect_hit = model_valid[fa.fields.set] && model_tag[fa.fields.set] == fa.fields.tag;
        ar_before  = ar_count;
        read_en    = 1'b1;
        addr       = fa;
        waited     = 0;
        @(negedge clk);
        while (!ready) begin
            next_cycle();
            @(negedge clk);
            waited++;
        end
        was_hit = waited == 0;
        if (was_hit != expect_hit) begin
            $display("** Error at %0t: hit = %0b, expected %0b (addr %h)",
                     $time, was_hit, expect_hit, a);
            error_count++;
        end
        if (data_out !== mem_word(a)) begin
            $display("** Error at %0t: data_out = %h, expected %h (addr %h)",
                     $time, data_out, mem_word(a), a);
            error_count++;
        end
        if (ar_count - ar_before != (expect_hit ? 0 : 1)) begin
            $display("** Error at %0t: AR requests = %0d, expected %0d (addr %h)",
                     $time, ar_count - ar_before, expect_hit ? 0 : 1, a);
            error_count++;
        end
        if (!expect_hit && last_araddr != {a[31:line_width], {line_width{1'b0}}}) begin
            $display("** Error at %0t: araddr = %h, expected %h",
                     $time, last_araddr, {a[31:line_width], {line_width{1'b0}}});
            error_count++;
        end
        model_valid[fa.fields.set] = 1'b1;
        model_tag[fa.fields.set]   = fa.fields.tag;
        next_cycle();
        read_en = 1'b0;
    endtask

    task automatic flush_all();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        for (int i = 0; i < line_count; i++) begin
            model_valid[i] = 1'b0;
        end
        next_cycle();
    endtask

    task automatic report_test(input int number, input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", number, name);
        end else begin
            $display("test %0d %s: %0d errors", number, name, error_count - errors_before);
        end
        tests_run++;
    endtask

    // AR handshake and R acceptance monitor sampled mid cycle
    always @(negedge clk) begin
        if (rst && rvalid && rready !== 1'b1) begin
            $display("** Error at %0t: rready = %b, expected 1", $time, rready);
            error_count++;
        end
        if (rst && arvalid && arready) begin
            ar_count++;
            last_araddr = araddr;
            if (arlen != 8'd3 || arsize != 3'd2 || arburst != 2'd1) begin
                $display("** Error at %0t: arlen/arsize/arburst = %0d/%0d/%0d, expected 3/2/1",
                         $time, arlen, arsize, arburst);
                error_count++;
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, a read never completed", watchdog_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic        hit;
        logic [31:0] base;
        int          start;
        clk         = 1'b0;
        rst         = 1'b0;
        read_en     = 1'b0;
        flush       = 1'b0;
        addr        = '0;
        ar_hold     = 1'b0;
        r_hold      = 1'b0;
        lfsr        = seed;
        gaps_on     = 1'b0;
        error_count = 0;
        tests_run   = 0;
        ar_count    = 0;
        last_araddr = 32'd0;
        for (int i = 0; i < line_count; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;

        start = error_count;
        @(negedge clk);
        if (ready !== 1'b0) begin
            $display("** Error at %0t: ready = %b, expected 0", $time, ready);
            error_count++;
        end
        if (arvalid !== 1'b0) begin
            $display("** Error at %0t: arvalid = %b, expected 0", $time, arvalid);
            error_count++;
        end
        next_cycle();
        fetch(random_bits(10), hit);
        report_test(1, "reset and first miss", start);

        start = error_count;
        for (int i = 0; i < random_reads; i++) begin
            fetch(random_bits(10), hit);
        end
        report_test(2, "random reads", start);

        start = error_count;
        base = random_bits(10) & 32'hffff_fff0;
        fetch(base, hit);
        for (int w = 0; w < 4; w++) begin
            fetch(base | (32'(w) << 2), hit);
            if (!hit) begin
                $display("repeated read of a held line at %h did not hit", base);
                error_count++;
            end
        end
        report_test(3, "repeated hits", start);

        start = error_count;
        base = random_bits(10);
        for (int i = 0; i < evict_reads; i++) begin
            fetch(i % 2 == 0 ? base : base ^ 32'h100, hit);
            if (i > 0 && hit) begin
                $display("read %0d of the eviction pair hit, the other tag should own the set",
                         i);
                error_count++;
            end
        end
        report_test(4, "set eviction", start);

        start = error_count;
        for (int i = 0; i < line_count; i++) begin
            fetch(32'(i) * 32'd16 + (random_bits(2) << 2), hit);
        end
        flush_all();
        for (int i = 0; i < line_count; i++) begin
            fetch(32'(i) * 32'd16 + (random_bits(2) << 2), hit);
            if (hit) begin
                $display("line %0d still hit after flush", i);
                error_count++;
            end
        end
        report_test(5, "flush", start);

        start = error_count;
        gaps_on = 1'b1;
        for (int i = 0; i < gap_reads; i++) begin
            fetch(random_bits(12), hit);
        end
        gaps_on = 1'b0;
        report_test(6, "memory gaps", start);

        $display("%0d tests run, %0d errors", tests_run, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
design/icache_pkg.sv
design/cache_line.sv
design/axi_read_burst.sv
design/inst_cache.sv
design/icache_top.sv
verif/axi_mem_model.sv
verif/icache_assert.sv
verif/tb_icache.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_icache -o tb_icache

# tee keeps the log on screen, the grep below decides the result
./obj_dir/tb_icache | tee sim.log

grep -q "^PASS: all tests$" sim.log
echo "simulation passed"
